//--- Makefile
# Verilator build and run for the switch endpoint testbench.

VERILATOR ?= verilator
TOP       ?= tb_switch_endpoint_wrapper
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

//--- bus_types_pkg.sv
`default_nettype none

`include "chiplet_macros.svh"

package bus_types_pkg;
    import chiplet_types_pkg::*;

    typedef struct packed {
        logic                  wen;
        logic                  ren;
        logic [`ADDR_W-1:0]    addr;
        logic [`DATA_W-1:0]    wdata;
        logic [`DATA_W/8-1:0]  strobe;
    } bus_req_t;

    // all fields are combinational in the access cycle.
    typedef struct packed {
        logic [`DATA_W-1:0] rdata;
        logic               error;
        logic               request_stall;
    } bus_rsp_t;

    typedef enum logic [2:0] {
        SEL_TX_CFG,
        SEL_TX_DATA,
        SEL_RX_DATA,
        SEL_STATUS,
        SEL_NONE
    } reg_sel_t;

    typedef struct packed {
        node_id_t dest;
        vc_id_t   vc;
    } tx_cfg_t;

endpackage

`default_nettype wire

//--- chiplet_macros.svh
`ifndef CHIPLET_MACROS_SVH
`define CHIPLET_MACROS_SVH

// network sizing.
`define NODE_ID_W    2
`define NUM_VCS      2
`define PAYLOAD_W    32
`define LOCAL_NODE   0

// bus sizing.
`define ADDR_W       32
`define DATA_W       32

// buffer depths and credits.
`define VC_DEPTH     8
`define TX_DEPTH     4
`define RX_DEPTH     4
`define LINK_CREDITS 2

// endpoint register map, byte offsets.
`define REG_TX_CFG   32'h0
`define REG_TX_DATA  32'h4
`define REG_RX_DATA  32'h8
`define REG_STATUS   32'hC

`endif

//--- chiplet_types_pkg.sv
`default_nettype none

`include "chiplet_macros.svh"

package chiplet_types_pkg;

    // ##################################################
    // identifiers
    // ##################################################

    typedef logic [`NODE_ID_W-1:0] node_id_t;

    // one bit is enough for two virtual channels.
    typedef logic [0:0] vc_id_t;

    typedef logic [`PAYLOAD_W-1:0] payload_t;

    // ##################################################
    // flit and credit vectors
    // ##################################################

    // single-flit packet, vc sits in the top bit.
    typedef struct packed {
        vc_id_t   vc;
        node_id_t dest;
        node_id_t src;
        payload_t payload;
    } flit_t;

    // one pulse or level per virtual channel.
    typedef logic [`NUM_VCS-1:0] credit_vec_t;

endpackage

`default_nettype wire

//--- compile.f
+incdir+.
chiplet_types_pkg.sv
bus_types_pkg.sv
endpoint_regs.sv
endpoint.sv
vc_buffer.sv
switch.sv
switch_endpoint_wrapper.sv
tb_switch_endpoint_wrapper.sv

//--- endpoint.sv
`default_nettype none
`timescale 1ns/10ps

`include "chiplet_macros.svh"

module endpoint
    import chiplet_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  flit_t                      tx_flit,
    input  logic                       tx_push,
    input  logic                       rx_pop,
    output logic                       tx_full,
    output logic [$clog2(`TX_DEPTH):0] tx_count,
    output logic [$clog2(`RX_DEPTH):0] rx_count,
    output flit_t                      rx_head,
    output flit_t                      ep_flit,
    output logic                       ep_valid,
    input  credit_vec_t                sw_buf_avail,
    input  flit_t                      sw_flit,
    input  logic                       sw_valid,
    output logic                       ep_credit
);
    localparam int TX_PTR_W = $clog2(`TX_DEPTH);
    localparam int RX_PTR_W = $clog2(`RX_DEPTH);
    localparam logic [RX_PTR_W:0] RX_MAX = `RX_DEPTH;
    localparam logic [TX_PTR_W:0] TX_MAX = `TX_DEPTH;

    // ##################################################
    // transmit FIFO, bus side to switch
    // ##################################################

    flit_t               tx_mem [`TX_DEPTH];
    logic [TX_PTR_W-1:0] tx_wr_ptr;
    logic [TX_PTR_W-1:0] tx_rd_ptr;
    flit_t               tx_head;
    logic                tx_pop;

    assign tx_head = tx_mem[tx_rd_ptr];
    assign tx_full = tx_count == TX_MAX;

    // issue the head only when its vc buffer in the switch has room.
    assign tx_pop   = tx_count != '0 && sw_buf_avail[tx_head.vc];
    assign ep_valid = tx_pop;
    assign ep_flit  = tx_head;

    always_ff @(posedge clk) begin
        if (tx_push) tx_mem[tx_wr_ptr] <= tx_flit;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_wr_ptr <= '0;
            tx_rd_ptr <= '0;
            tx_count  <= '0;
        end else begin
            if (tx_push) tx_wr_ptr <= tx_wr_ptr + 1'b1;
            if (tx_pop) tx_rd_ptr <= tx_rd_ptr + 1'b1;
            case ({tx_push, tx_pop})
                2'b10:   tx_count <= tx_count + 1'b1;
                2'b01:   tx_count <= tx_count - 1'b1;
                default: ;
            endcase
        end
    end

    // ##################################################
    // receive FIFO, switch to bus side
    // ##################################################

    flit_t               rx_mem [`RX_DEPTH];
    logic [RX_PTR_W-1:0] rx_wr_ptr;
    logic [RX_PTR_W-1:0] rx_rd_ptr;

    assign rx_head = rx_mem[rx_rd_ptr];

    always_ff @(posedge clk) begin
        if (sw_valid) rx_mem[rx_wr_ptr] <= sw_flit;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_wr_ptr <= '0;
            rx_rd_ptr <= '0;
            rx_count  <= '0;
            ep_credit <= 1'b0;
        end else begin
            if (sw_valid) rx_wr_ptr <= rx_wr_ptr + 1'b1;
            if (rx_pop) rx_rd_ptr <= rx_rd_ptr + 1'b1;
            case ({sw_valid, rx_pop})
                2'b10:   rx_count <= rx_count + 1'b1;
                2'b01:   rx_count <= rx_count - 1'b1;
                default: ;
            endcase
            // every freed entry goes back to the switch as one credit.
            ep_credit <= rx_pop;
        end
    end

    // the switch credit count must keep the receive FIFO from overflowing.
    a_rx_no_overrun: assert property (@(posedge clk) disable iff (rst)
        sw_valid |-> rx_count != RX_MAX);

endmodule

`default_nettype wire

//--- endpoint_regs.sv
`default_nettype none
`timescale 1ns/10ps

`include "chiplet_macros.svh"

module endpoint_regs
    import chiplet_types_pkg::*;
    import bus_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  bus_req_t                   bus_req,
    output bus_rsp_t                   bus_rsp,
    output flit_t                      tx_flit,
    output logic                       tx_push,
    output logic                       rx_pop,
    input  logic                       tx_full,
    input  logic [$clog2(`TX_DEPTH):0] tx_count,
    input  logic [$clog2(`RX_DEPTH):0] rx_count,
    input  flit_t                      rx_head
);
    reg_sel_t sel;
    tx_cfg_t  tx_cfg;
    logic     full_strobe;
    logic     data_wr;
    logic     rx_empty;

    always_comb begin
        case (bus_req.addr)
            `REG_TX_CFG:  sel = SEL_TX_CFG;
            `REG_TX_DATA: sel = SEL_TX_DATA;
            `REG_RX_DATA: sel = SEL_RX_DATA;
            `REG_STATUS:  sel = SEL_STATUS;
            default:      sel = SEL_NONE;
        endcase
    end

    assign full_strobe = &bus_req.strobe;
    assign data_wr     = bus_req.wen && sel == SEL_TX_DATA && full_strobe;
    assign rx_empty    = rx_count == '0;

    assign tx_push = data_wr && !tx_full;
    assign rx_pop  = bus_req.ren && sel == SEL_RX_DATA && !rx_empty;

    assign tx_flit = '{vc: tx_cfg.vc, dest: tx_cfg.dest,
                       src: node_id_t'(`LOCAL_NODE), payload: bus_req.wdata};

    // dest lives in byte 0, vc in byte 1.
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_cfg <= '0;
        end else if (bus_req.wen && sel == SEL_TX_CFG) begin
            if (bus_req.strobe[0]) tx_cfg.dest <= bus_req.wdata[`NODE_ID_W-1:0];
            if (bus_req.strobe[1]) tx_cfg.vc <= bus_req.wdata[8];
        end
    end

    always_comb begin
        bus_rsp.rdata = '0;
        case (sel)
            SEL_TX_CFG: begin
                bus_rsp.rdata[`NODE_ID_W-1:0] = tx_cfg.dest;
                bus_rsp.rdata[8]              = tx_cfg.vc;
            end
            SEL_RX_DATA: if (!rx_empty) bus_rsp.rdata = rx_head.payload;
            SEL_STATUS: begin
                bus_rsp.rdata[2:0] = tx_count;
                bus_rsp.rdata[6:4] = rx_count;
                bus_rsp.rdata[9:8] = rx_head.src;
            end
            default: ;
        endcase
        bus_rsp.error = ((bus_req.wen || bus_req.ren) && sel == SEL_NONE)
                      || (bus_req.ren && sel == SEL_RX_DATA && rx_empty)
                      || (bus_req.wen && sel == SEL_TX_DATA && !full_strobe)
                      || (bus_req.wen && sel == SEL_STATUS);
        // master holds the write until the transmit FIFO drains.
        bus_rsp.request_stall = data_wr && tx_full;
    end

    // a push always finds a free transmit entry.
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        tx_push |-> tx_count < `TX_DEPTH);

endmodule

`default_nettype wire

//--- switch.sv
`default_nettype none
`timescale 1ns/10ps

`include "chiplet_macros.svh"

module switch
    import chiplet_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  flit_t       ep_flit,
    input  logic        ep_valid,
    output credit_vec_t sw_buf_avail,
    output flit_t       sw_flit,
    output logic        sw_valid,
    input  logic        ep_credit,
    input  flit_t       in_flit,
    input  logic        data_ready_in,
    output flit_t       out_flit,
    output logic        data_ready_out,
    input  logic        packet_sent,
    input  credit_vec_t credit_granted
);
    localparam int LINK_CW = $clog2(`LINK_CREDITS) + 1;
    localparam int EP_CW = $clog2(`RX_DEPTH) + 1;
    localparam logic [LINK_CW-1:0] LINK_INIT = `LINK_CREDITS;
    localparam logic [EP_CW-1:0] EP_INIT = `RX_DEPTH;

    flit_t [`NUM_VCS-1:0] ep_head;
    flit_t [`NUM_VCS-1:0] link_head;
    credit_vec_t          ep_ne;
    credit_vec_t          link_ne;

    // requester index is {input port, vc}.
    flit_t [3:0]          heads;
    logic [3:0]           ne;
    logic [3:0]           to_link;
    logic [3:0]           req [2];
    logic [1:0]           rr_last [2];
    logic [1:0]           gnt_idx [2];
    logic [1:0]           gnt_valid;
    logic [1:0]           rd_en;
    vc_id_t               rd_vc [2];
    vc_id_t               link_vc;
    logic                 link_free;
    logic [LINK_CW-1:0]   link_credit [`NUM_VCS];
    logic [EP_CW-1:0]     ep_credit_cnt;

    vc_buffer u_ep_buf (
        .clk       (clk),
        .rst       (rst),
        .wr_flit   (ep_flit),
        .wr_en     (ep_valid),
        .rd_vc     (rd_vc[0]),
        .rd_en     (rd_en[0]),
        .head      (ep_head),
        .not_empty (ep_ne),
        .avail     (sw_buf_avail)
    );

    vc_buffer u_link_buf (
        .clk       (clk),
        .rst       (rst),
        .wr_flit   (in_flit),
        .wr_en     (data_ready_in),
        .rd_vc     (rd_vc[1]),
        .rd_en     (rd_en[1]),
        .head      (link_head),
        .not_empty (link_ne),
        .avail     ()
    );

    assign heads = {link_head, ep_head};
    assign ne    = {link_ne, ep_ne};

    // the link register can reload in the cycle its flit is taken.
    assign link_free = !data_ready_out || packet_sent;

    // ##################################################
    // routing and round-robin arbitration
    // ##################################################

    always_comb begin
        for (int r = 0; r < 4; r++) begin
            to_link[r] = heads[r].dest != node_id_t'(`LOCAL_NODE);
            req[1][r]  = ne[r] && to_link[r] && link_free
                         && link_credit[heads[r].vc] != '0;
            req[0][r]  = ne[r] && !to_link[r] && ep_credit_cnt != '0;
        end
    end

    // link output picks first; the endpoint output skips that input port.
    always_comb begin
        logic [3:0] cand;
        logic [1:0] idx;
        gnt_valid  = '0;
        gnt_idx[0] = '0;
        gnt_idx[1] = '0;
        for (int o = 1; o >= 0; o--) begin
            cand = req[o];
            if (o == 0 && gnt_valid[1]) cand &= gnt_idx[1][1] ? 4'b0011 : 4'b1100;
            for (int k = 1; k <= 4; k++) begin
                idx = rr_last[o] + 2'(k);
                if (!gnt_valid[o] && cand[idx]) begin
                    gnt_valid[o] = 1'b1;
                    gnt_idx[o]   = idx;
                end
            end
        end
    end

    always_comb begin
        rd_en    = '0;
        rd_vc[0] = '0;
        rd_vc[1] = '0;
        for (int o = 0; o < 2; o++) begin
            if (gnt_valid[o]) begin
                rd_en[gnt_idx[o][1]] = 1'b1;
                rd_vc[gnt_idx[o][1]] = gnt_idx[o][0];
            end
        end
    end

    assign link_vc = heads[gnt_idx[1]].vc;

    // ##################################################
    // output registers and credit counters
    // ##################################################

    always_ff @(posedge clk) begin
        if (gnt_valid[1]) out_flit <= heads[gnt_idx[1]];
        if (gnt_valid[0]) sw_flit <= heads[gnt_idx[0]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_ready_out <= 1'b0;
            sw_valid       <= 1'b0;
            ep_credit_cnt  <= EP_INIT;
            for (int o = 0; o < 2; o++) rr_last[o] <= 2'd3;
            for (int v = 0; v < `NUM_VCS; v++) link_credit[v] <= LINK_INIT;
        end else begin
            sw_valid <= gnt_valid[0];
            if (gnt_valid[1]) begin
                data_ready_out <= 1'b1;
            end else if (packet_sent) begin
                data_ready_out <= 1'b0;
            end
            for (int o = 0; o < 2; o++) begin
                if (gnt_valid[o]) rr_last[o] <= gnt_idx[o];
            end
            for (int v = 0; v < `NUM_VCS; v++) begin
                case ({gnt_valid[1] && link_vc == vc_id_t'(v), credit_granted[v]})
                    2'b10:   link_credit[v] <= link_credit[v] - 1'b1;
                    2'b01:   link_credit[v] <= link_credit[v] + 1'b1;
                    default: ;
                endcase
            end
            case ({gnt_valid[0], ep_credit})
                2'b10:   ep_credit_cnt <= ep_credit_cnt - 1'b1;
                2'b01:   ep_credit_cnt <= ep_credit_cnt + 1'b1;
                default: ;
            endcase
        end
    end

    // returned credits never outnumber those handed out.
    for (genvar v = 0; v < `NUM_VCS; v++) begin : g_credit_chk
        a_link_credit_max: assert property (@(posedge clk) disable iff (rst)
            link_credit[v] <= LINK_INIT);
    end

    a_ep_credit_max: assert property (@(posedge clk) disable iff (rst)
        ep_credit_cnt <= EP_INIT);

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        data_ready_out && !packet_sent |=> data_ready_out && $stable(out_flit));

endmodule

`default_nettype wire

//--- switch_endpoint_wrapper.sv
`default_nettype none
`timescale 1ns/10ps

`include "chiplet_macros.svh"

module switch_endpoint_wrapper
    import chiplet_types_pkg::*;
    import bus_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // bus side.
    input  logic                 wen,
    input  logic                 ren,
    input  logic [`ADDR_W-1:0]   addr,
    input  logic [`DATA_W-1:0]   wdata,
    input  logic [`DATA_W/8-1:0] strobe,
    output logic [`DATA_W-1:0]   rdata,
    output logic                 error,
    output logic                 request_stall,
    // external link.
    input  flit_t                in_flit,
    input  logic                 data_ready_in,
    output flit_t                out_flit,
    output logic                 data_ready_out,
    input  logic                 packet_sent,
    input  credit_vec_t          credit_granted
);
    bus_req_t                   bus_req;
    bus_rsp_t                   bus_rsp;
    flit_t                      tx_flit;
    flit_t                      rx_head;
    flit_t                      ep_flit;
    flit_t                      sw_flit;
    logic                       tx_push;
    logic                       rx_pop;
    logic                       tx_full;
    logic [$clog2(`TX_DEPTH):0] tx_count;
    logic [$clog2(`RX_DEPTH):0] rx_count;
    logic                       ep_valid;
    logic                       sw_valid;
    logic                       ep_credit;
    credit_vec_t                sw_buf_avail;

    assign bus_req = '{wen: wen, ren: ren, addr: addr, wdata: wdata, strobe: strobe};

    assign rdata         = bus_rsp.rdata;
    assign error         = bus_rsp.error;
    assign request_stall = bus_rsp.request_stall;

    endpoint_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .tx_flit  (tx_flit),
        .tx_push  (tx_push),
        .rx_pop   (rx_pop),
        .tx_full  (tx_full),
        .tx_count (tx_count),
        .rx_count (rx_count),
        .rx_head  (rx_head)
    );

    endpoint u_endpoint (
        .clk          (clk),
        .rst          (rst),
        .tx_flit      (tx_flit),
        .tx_push      (tx_push),
        .rx_pop       (rx_pop),
        .tx_full      (tx_full),
        .tx_count     (tx_count),
        .rx_count     (rx_count),
        .rx_head      (rx_head),
        .ep_flit      (ep_flit),
        .ep_valid     (ep_valid),
        .sw_buf_avail (sw_buf_avail),
        .sw_flit      (sw_flit),
        .sw_valid     (sw_valid),
        .ep_credit    (ep_credit)
    );

    // port 0 faces the endpoint, port 1 the link.
    switch u_switch (
        .clk            (clk),
        .rst            (rst),
        .ep_flit        (ep_flit),
        .ep_valid       (ep_valid),
        .sw_buf_avail   (sw_buf_avail),
        .sw_flit        (sw_flit),
        .sw_valid       (sw_valid),
        .ep_credit      (ep_credit),
        .in_flit        (in_flit),
        .data_ready_in  (data_ready_in),
        .out_flit       (out_flit),
        .data_ready_out (data_ready_out),
        .packet_sent    (packet_sent),
        .credit_granted (credit_granted)
    );

endmodule

`default_nettype wire

//--- tb_switch_endpoint_wrapper.sv
`default_nettype none
`timescale 1ns/10ps

`include "chiplet_macros.svh"

module tb_switch_endpoint_wrapper
    import chiplet_types_pkg::*;
;
    localparam int TIMEOUT_CYCLES = 2000;
    // flits that fit behind a held link output before the bus stalls.
    localparam int FILL = `VC_DEPTH + 1 + `TX_DEPTH;

    logic                 clk;
    logic                 rst;
    logic                 wen;
    logic                 ren;
    logic [`ADDR_W-1:0]   addr;
    logic [`DATA_W-1:0]   wdata;
    logic [`DATA_W/8-1:0] strobe;
    logic [`DATA_W-1:0]   rdata;
    logic                 error;
    logic                 request_stall;
    flit_t                in_flit;
    logic                 data_ready_in;
    flit_t                out_flit;
    logic                 data_ready_out;
    logic                 packet_sent;
    credit_vec_t          credit_granted;

    int          errors;
    int          checks;
    int unsigned cycle_count;
    logic [31:0] rng_state;
    bit          stall_seen;

    switch_endpoint_wrapper UUT (
        .clk            (clk),
        .rst            (rst),
        .wen            (wen),
        .ren            (ren),
        .addr           (addr),
        .wdata          (wdata),
        .strobe         (strobe),
        .rdata          (rdata),
        .error          (error),
        .request_stall  (request_stall),
        .in_flit        (in_flit),
        .data_ready_in  (data_ready_in),
        .out_flit       (out_flit),
        .data_ready_out (data_ready_out),
        .packet_sent    (packet_sent),
        .credit_granted (credit_granted)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // ##################################################
    // helpers
    // ##################################################

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic flit_t make_flit(input vc_id_t vc, input node_id_t dest,
                                        input node_id_t src, input payload_t payload);
        flit_t f;
        f.vc      = vc;
        f.dest    = dest;
        f.src     = src;
        f.payload = payload;
        return f;
    endfunction

    // only dest in [1:0] and vc in bit 8 exist in TX_CFG.
    function automatic logic [31:0] merge_cfg(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] s);
        logic [31:0] m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) m[8*b +: 8] = d[8*b +: 8];
        end
        return m & 32'h0000_0103;
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name, input int err0);
        $display("test %0d, %s: %s", num, name, (errors == err0) ? "pass" : "fail");
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] s, input bit exp_err);
        @(negedge clk);
        wen    = 1'b1;
        addr   = a;
        wdata  = d;
        strobe = s;
        #1;
        // hold the access unchanged while the DUT stalls it.
        while (request_stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
            #1;
        end
        check_equal("bus write error", {63'd0, error}, {63'd0, exp_err});
        @(negedge clk);
        wen    = 1'b0;
        strobe = '0;
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d, input bit exp_err);
        @(negedge clk);
        ren  = 1'b1;
        addr = a;
        #1;
        d = rdata;
        check_equal("bus read error", {63'd0, error}, {63'd0, exp_err});
        @(negedge clk);
        ren = 1'b0;
    endtask

    task automatic wait_rx_count(input logic [2:0] n);
        logic [31:0] d;
        bus_read(`REG_STATUS, d, 1'b0);
        while (d[6:4] != n) bus_read(`REG_STATUS, d, 1'b0);
    endtask

    task automatic send_link_flit(input flit_t f);
        @(negedge clk);
        in_flit       = f;
        data_ready_in = 1'b1;
        @(negedge clk);
        data_ready_in = 1'b0;
    endtask

    task automatic grant_credit(input vc_id_t vc);
        @(negedge clk);
        credit_granted[vc] = 1'b1;
        @(negedge clk);
        credit_granted = '0;
    endtask

    // waits for the flit, checks it is held, then takes it off the link.
    task automatic expect_link_flit(input flit_t exp, input int hold, input bit give_credit);
        @(negedge clk);
        while (!data_ready_out) @(negedge clk);
        check_equal("out_flit", {27'd0, out_flit}, {27'd0, exp});
        for (int h = 0; h < hold; h++) begin
            @(negedge clk);
            check_equal("data_ready_out held", {63'd0, data_ready_out}, 64'd1);
            check_equal("out_flit held", {27'd0, out_flit}, {27'd0, exp});
        end
        packet_sent = 1'b1;
        if (give_credit) credit_granted[exp.vc] = 1'b1;
        @(negedge clk);
        packet_sent    = 1'b0;
        credit_granted = '0;
    endtask

    task automatic expect_link_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_equal("data_ready_out idle", {63'd0, data_ready_out}, 64'd0);
        end
    endtask

    // ##################################################
    // tests
    // ##################################################

    task automatic registers_access();
        int          err0;
        logic [31:0] cfg;
        logic [31:0] d;
        err0 = errors;
        cfg  = '0;
        bus_read(`REG_TX_CFG, d, 1'b0);
        check_equal("TX_CFG after reset", {32'd0, d}, {32'd0, cfg});
        bus_write(`REG_TX_CFG, 32'hFFFF_FFFF, 4'b0001, 1'b0);
        cfg = merge_cfg(cfg, 32'hFFFF_FFFF, 4'b0001);
        bus_read(`REG_TX_CFG, d, 1'b0);
        check_equal("TX_CFG byte 0", {32'd0, d}, {32'd0, cfg});
        bus_write(`REG_TX_CFG, 32'h0000_0100, 4'b0010, 1'b0);
        cfg = merge_cfg(cfg, 32'h0000_0100, 4'b0010);
        bus_read(`REG_TX_CFG, d, 1'b0);
        check_equal("TX_CFG byte 1", {32'd0, d}, {32'd0, cfg});
        bus_write(`REG_TX_CFG, 32'h0000_0002, 4'b1100, 1'b0);
        cfg = merge_cfg(cfg, 32'h0000_0002, 4'b1100);
        bus_read(`REG_TX_CFG, d, 1'b0);
        check_equal("TX_CFG upper bytes", {32'd0, d}, {32'd0, cfg});
        bus_write(`REG_TX_CFG, 32'h0000_0002, 4'b1111, 1'b0);
        cfg = merge_cfg(cfg, 32'h0000_0002, 4'b1111);
        bus_read(`REG_TX_CFG, d, 1'b0);
        check_equal("TX_CFG full word", {32'd0, d}, {32'd0, cfg});
        bus_write(32'h0000_0010, 32'h1234_5678, 4'hF, 1'b1);
        bus_read(32'h0000_0010, d, 1'b1);
        bus_write(`REG_STATUS, 32'h0, 4'hF, 1'b1);
        bus_write(`REG_TX_DATA, 32'hDEAD_BEEF, 4'b0111, 1'b1);
        // the rejected write must not have queued a flit.
        bus_read(`REG_STATUS, d, 1'b0);
        check_equal("STATUS tx count", {61'd0, d[2:0]}, 64'd0);
        report_test(1, "registers", err0);
    endtask

    task automatic endpoint_to_link();
        int    err0;
        flit_t f;
        err0 = errors;
        bus_write(`REG_TX_CFG, 32'h0000_0102, 4'b0011, 1'b0);
        f = make_flit(1'b1, 2'd2, node_id_t'(`LOCAL_NODE), next_random());
        bus_write(`REG_TX_DATA, f.payload, 4'hF, 1'b0);
        expect_link_flit(f, 4, 1'b1);
        check_equal("data_ready_out after packet_sent", {63'd0, data_ready_out}, 64'd0);
        report_test(2, "endpoint to link", err0);
    endtask

    task automatic link_to_endpoint();
        int          err0;
        flit_t       f [3];
        logic [31:0] d;
        err0 = errors;
        for (int i = 0; i < 3; i++) begin
            f[i] = make_flit(1'b1, node_id_t'(`LOCAL_NODE), node_id_t'(i + 1), next_random());
            send_link_flit(f[i]);
        end
        wait_rx_count(3'd3);
        for (int i = 0; i < 3; i++) begin
            bus_read(`REG_STATUS, d, 1'b0);
            check_equal("STATUS rx source", {62'd0, d[9:8]}, {62'd0, f[i].src});
            bus_read(`REG_RX_DATA, d, 1'b0);
            check_equal("RX_DATA payload", {32'd0, d}, {32'd0, f[i].payload});
        end
        bus_read(`REG_RX_DATA, d, 1'b1);
        report_test(3, "link to endpoint", err0);
    endtask

    task automatic loopback();
        int          err0;
        payload_t    p [3];
        logic [31:0] d;
        err0 = errors;
        bus_write(`REG_TX_CFG, 32'h0000_0000, 4'b0011, 1'b0);
        for (int i = 0; i < 3; i++) begin
            p[i] = next_random();
            bus_write(`REG_TX_DATA, p[i], 4'hF, 1'b0);
        end
        wait_rx_count(3'd3);
        for (int i = 0; i < 3; i++) begin
            bus_read(`REG_STATUS, d, 1'b0);
            check_equal("loopback source", {62'd0, d[9:8]}, 64'(`LOCAL_NODE));
            bus_read(`REG_RX_DATA, d, 1'b0);
            check_equal("loopback payload", {32'd0, d}, {32'd0, p[i]});
        end
        report_test(4, "loopback", err0);
    endtask

    task automatic link_credits();
        int    err0;
        flit_t f [3];
        flit_t v;
        err0 = errors;
        bus_write(`REG_TX_CFG, 32'h0000_0002, 4'b0011, 1'b0);
        for (int i = 0; i < 3; i++) begin
            f[i] = make_flit(1'b0, 2'd2, node_id_t'(`LOCAL_NODE), next_random());
            bus_write(`REG_TX_DATA, f[i].payload, 4'hF, 1'b0);
        end
        expect_link_flit(f[0], 0, 1'b0);
        expect_link_flit(f[1], 0, 1'b0);
        expect_link_idle(10);
        // vc 1 still has credit while vc 0 is starved.
        bus_write(`REG_TX_CFG, 32'h0000_0102, 4'b0011, 1'b0);
        v = make_flit(1'b1, 2'd2, node_id_t'(`LOCAL_NODE), next_random());
        bus_write(`REG_TX_DATA, v.payload, 4'hF, 1'b0);
        expect_link_flit(v, 0, 1'b1);
        expect_link_idle(4);
        grant_credit(1'b0);
        expect_link_flit(f[2], 0, 1'b1);
        grant_credit(1'b0);
        report_test(5, "link credits", err0);
    endtask

    task automatic transmit_stall();
        int          err0;
        flit_t       f [FILL + 1];
        logic [31:0] d;
        err0 = errors;
        bus_write(`REG_TX_CFG, 32'h0000_0002, 4'b0011, 1'b0);
        for (int i = 0; i <= FILL; i++) begin
            f[i] = make_flit(1'b0, 2'd2, node_id_t'(`LOCAL_NODE), next_random());
        end
        stall_seen = 1'b0;
        for (int i = 0; i < FILL; i++) bus_write(`REG_TX_DATA, f[i].payload, 4'hF, 1'b0);
        check_equal("stall before queue full", {63'd0, stall_seen}, 64'd0);
        fork
            bus_write(`REG_TX_DATA, f[FILL].payload, 4'hF, 1'b0);
            begin
                @(negedge clk);
                #1;
                while (!request_stall) begin
                    @(negedge clk);
                    #1;
                end
                for (int i = 0; i <= FILL; i++) expect_link_flit(f[i], 0, 1'b1);
            end
        join
        check_equal("stall on full queue", {63'd0, stall_seen}, 64'd1);
        // nothing may follow the last flit.
        expect_link_idle(8);
        bus_read(`REG_STATUS, d, 1'b0);
        check_equal("STATUS tx count drained", {61'd0, d[2:0]}, 64'd0);
        report_test(6, "transmit stall", err0);
    endtask

    // ##################################################
    // main sequence
    // ##################################################

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        wen            = 1'b0;
        ren            = 1'b0;
        addr           = '0;
        wdata          = '0;
        strobe         = '0;
        in_flit        = '0;
        data_ready_in  = 1'b0;
        packet_sent    = 1'b0;
        credit_granted = '0;
        errors         = 0;
        checks         = 0;
        cycle_count    = 0;
        rng_state      = 32'd42;
        stall_seen     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        registers_access();
        endpoint_to_link();
        link_to_endpoint();
        loopback();
        link_credits();
        transmit_stall();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vc_buffer.sv
`default_nettype none
`timescale 1ns/10ps

`include "chiplet_macros.svh"

module vc_buffer
    import chiplet_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  flit_t                     wr_flit,
    input  logic                      wr_en,
    input  vc_id_t                    rd_vc,
    input  logic                      rd_en,
    output flit_t [`NUM_VCS-1:0]      head,
    output credit_vec_t               not_empty,
    output credit_vec_t               avail
);
    localparam int PTR_W = $clog2(`VC_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `VC_DEPTH;

    for (genvar v = 0; v < `NUM_VCS; v++) begin : g_vc
        flit_t            mem [`VC_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W:0]   count;
        logic             push;
        logic             pop;

        assign push = wr_en && wr_flit.vc == vc_id_t'(v);
        assign pop  = rd_en && rd_vc == vc_id_t'(v);

        assign head[v]      = mem[rd_ptr];
        assign not_empty[v] = count != '0;
        assign avail[v]     = count != DEPTH;

        always_ff @(posedge clk) begin
            if (push) mem[wr_ptr] <= wr_flit;
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) wr_ptr <= wr_ptr + 1'b1;
                if (pop) rd_ptr <= rd_ptr + 1'b1;
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // senders must respect avail, the link sender included.
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> avail[wr_flit.vc]);

endmodule

`default_nettype wire
